/* design/obj_pkg.sv */
// shared widths, fetch states and pixel unpacking for the sprite line renderer; import in each block
package obj_pkg;

    localparam logic [7:0] obj_hoffset = 8'd6; // screen offset, also blanking delay + 1
    localparam int obj_buf_aw = 8;             // 256 line positions
    localparam int obj_code_w = 9;
    localparam int obj_rom_aw = 14;            // code, row, half
    localparam int obj_pxl_w  = 4;

    typedef enum logic [1:0] {
        idle,
        wait_rom,   // rom_cs held until rom_ok
        shift       // one pixel per cen
    } obj_state_e;

    // eight 4bpp pixels from one graphics word, pixel 0 in the low nibble
    // planes are interleaved: each nibble of the word holds one plane bit of four pixels
    function automatic logic [8*obj_pxl_w-1:0] obj_unpack(input logic [31:0] word);
        logic [8*obj_pxl_w-1:0] pix;
        int k;
        int base;
        pix = '0;
        for (int n = 0; n < 8; n++) begin
            k    = n % 4;
            base = (n < 4) ? 0 : 16;  // upper half of the word feeds pixels 4-7
            pix[n*obj_pxl_w +: obj_pxl_w] = {
                word[base+8+k],
                word[base+12+k],
                word[base+k],
                word[base+4+k]
            };
        end
        return pix;
    endfunction

endpackage

/* design/obj_req_if.sv */
// one sprite draw request from the host side and the busy reply from the fetch engine
`timescale 1ns/1ps

interface obj_req_if;
    import obj_pkg::*;

    logic                  draw;   // start strobe, taken when busy is low
    logic [obj_code_w-1:0] code;
    logic [3:0]            row;    // row inside the 16x16 sprite
    logic [obj_buf_aw-1:0] xpos;
    logic [obj_pxl_w-1:0]  pal;    // palette bank
    logic                  hflip;
    logic                  vflip;
    logic                  busy;

    modport host (
        output draw, code, row, xpos, pal, hflip, vflip,
        input  busy
    );

    modport drawer (
        input  draw, code, row, xpos, pal, hflip, vflip,
        output busy
    );

endinterface

/* design/obj_fetch.sv */
// sprite fetch engine: takes a draw request, reads two ROM words and emits 16 pixels to the palette
`timescale 1ns/1ps

module obj_fetch (
    input  logic                            rst,
    input  logic                            clk,
    input  logic                            cen,
    obj_req_if.drawer                       req,
    output logic [obj_pkg::obj_rom_aw-1:0]  rom_addr,
    input  logic [31:0]                     rom_data,
    output logic                            rom_cs,
    input  logic                            rom_ok,
    output logic [2*obj_pkg::obj_pxl_w-1:0] pal_addr,
    output logic [obj_pkg::obj_buf_aw-1:0]  wr_addr,
    output logic                            wr_en
);
    import obj_pkg::*;

    obj_state_e             state;
    logic                   busy;
    logic                   start;
    logic [2:0]             cnt;      // pixel index within the current word
    logic                   hflip_l;
    logic [obj_buf_aw-1:0]  buf_a;
    logic [8*obj_pxl_w-1:0] pix_sh;   // unpacked word, low nibble goes out first
    logic [obj_pxl_w-1:0]   pal_l;

    assign start    = cen && req.draw && !busy; // draws during busy are dropped
    assign req.busy = busy;

    assign pal_addr = {pal_l, pix_sh[obj_pxl_w-1:0]};
    assign wr_addr  = buf_a;
    assign wr_en    = cen && (state == shift);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            busy     <= 1'b0;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            cnt      <= '0;
            hflip_l  <= 1'b0;
            buf_a    <= '0;
        end else if (cen) begin
            case (state)
                idle: begin
                    if (start) begin
                        rom_addr <= {req.code, req.row ^ {4{req.vflip}}, 1'b0};
                        rom_cs   <= 1'b1;
                        busy     <= 1'b1;
                        hflip_l  <= req.hflip;
                        // flipped sprites start at the right edge and walk left
                        buf_a    <= req.xpos + obj_hoffset + (req.hflip ? 8'd15 : 8'd0);
                        state    <= wait_rom;
                    end
                end
                wait_rom: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                        state  <= shift;
                    end
                end
                shift: begin
                    buf_a <= hflip_l ? buf_a - 8'd1 : buf_a + 8'd1;
                    cnt   <= cnt + 3'd1;
                    if (cnt == 3'd7) begin
                        if (rom_addr[0]) begin
                            busy  <= 1'b0;       // both halves done
                            state <= idle;
                        end else begin
                            rom_addr[0] <= 1'b1; // second word, same code and row
                            rom_cs      <= 1'b1;
                            state       <= wait_rom;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // pixel data path
    always_ff @(posedge clk) begin
        if (cen) begin
            if (start)
                pal_l <= req.pal;
            if (state == wait_rom && rom_ok)
                pix_sh <= obj_unpack(rom_data);
            else if (state == shift)
                pix_sh <= pix_sh >> obj_pxl_w;
        end
    end

    // the ROM may take any number of cycles, the address must not move meanwhile
    a_rom_addr_hold: assert property (
        @(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr)
    );

    // pixels only inside a request, never after busy has dropped
    a_wr_in_busy: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> busy
    );

endmodule

/* design/obj_palette.sv */
// programmable 256x4 colour PROM on the sprite write path, keeps buffer address aligned to the read
`timescale 1ns/1ps

module obj_palette (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [2*obj_pkg::obj_pxl_w-1:0] prog_addr,
    input  logic [obj_pkg::obj_pxl_w-1:0]   prog_data,
    input  logic                            prog_en,
    input  logic [2*obj_pkg::obj_pxl_w-1:0] pal_addr,
    input  logic [obj_pkg::obj_buf_aw-1:0]  wr_addr,
    input  logic                            wr_en,
    output logic [obj_pkg::obj_pxl_w-1:0]   buf_data,
    output logic [obj_pkg::obj_buf_aw-1:0]  buf_addr,
    output logic                            buf_we
);
    import obj_pkg::*;

    localparam int depth = 1 << (2*obj_pxl_w);

    logic [obj_pxl_w-1:0] prom [0:depth-1];

    // programming port and synchronous lookup, {bank, pixel} in
    always_ff @(posedge clk) begin
        if (prog_en)
            prom[prog_addr] <= prog_data;
        buf_data <= prom[pal_addr];
    end

    // position travels with the colour
    always_ff @(posedge clk) begin
        buf_addr <= wr_addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            buf_we <= 1'b0;
        else
            buf_we <= wr_en;
    end

endmodule

/* design/obj_line_buffer.sv */
// double-banked sprite line buffer between the palette stage and the pixel output, swapped by hinit
`timescale 1ns/1ps

module obj_line_buffer (
    input  logic                           rst,
    input  logic                           clk,
    input  logic                           pxl_cen,
    input  logic                           lhbl,
    input  logic                           hinit,
    input  logic [obj_pkg::obj_buf_aw-1:0] hdump,
    input  logic [obj_pkg::obj_pxl_w-1:0]  buf_data,
    input  logic [obj_pkg::obj_buf_aw-1:0] buf_addr,
    input  logic                           buf_we,
    output logic [obj_pkg::obj_pxl_w-1:0]  pxl
);
    import obj_pkg::*;

    localparam int dly_len = int'(obj_hoffset) - 1;
    localparam int depth   = 1 << obj_buf_aw;

    logic                 sel;          // visible bank
    logic [dly_len-1:0]   lhbl_sh;
    logic                 lhbl_dly;
    logic                 rd_stb;
    logic [obj_pxl_w-1:0] rd_q [2];

    assign lhbl_dly = lhbl_sh[dly_len-1];
    assign rd_stb   = pxl_cen && lhbl_dly;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel     <= 1'b0;
            lhbl_sh <= '0;
        end else begin
            if (hinit)
                sel <= ~sel;  // last drawn line becomes visible
            if (pxl_cen)
                lhbl_sh <= {lhbl_sh[dly_len-2:0], lhbl}; // matches the sprite x offset
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [obj_pxl_w-1:0] mem [0:depth-1];
        logic                 hidden;

        assign hidden = (sel != 1'(b));
        assign rd_q[b] = mem[hdump];

        initial begin
            for (int i = 0; i < depth; i++)
                mem[i] = '0;  // blank at power-up
        end

        always @(posedge clk) begin
            if (hidden) begin
                if (buf_we && buf_data != '0)  // colour 0 is see-through
                    mem[buf_addr] <= buf_data;
            end else if (rd_stb) begin
                mem[hdump] <= '0;              // erase behind the beam
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pxl <= '0;
        else if (rd_stb)
            pxl <= rd_q[sel];
    end

    // a write across the swap would land in the wrong bank
    a_no_we_at_hinit: assert property (
        @(posedge clk) disable iff (rst)
        !(buf_we && hinit)
    );

endmodule

/* design/obj_draw.sv */
// sprite line renderer top level: request port, ROM port, palette programming and pixel output
`timescale 1ns/1ps

module obj_draw (
    input  logic                            rst,
    input  logic                            clk,
    input  logic                            cen,
    input  logic                            pxl_cen,
    input  logic                            lhbl,
    input  logic                            hinit,
    input  logic [obj_pkg::obj_buf_aw-1:0]  hdump,
    input  logic                            draw,
    input  logic [obj_pkg::obj_code_w-1:0]  code,
    input  logic [3:0]                      row,
    input  logic [obj_pkg::obj_buf_aw-1:0]  xpos,
    input  logic [obj_pkg::obj_pxl_w-1:0]   pal,
    input  logic                            hflip,
    input  logic                            vflip,
    output logic                            busy,
    input  logic [2*obj_pkg::obj_pxl_w-1:0] prog_addr,
    input  logic [obj_pkg::obj_pxl_w-1:0]   prog_data,
    input  logic                            prog_en,
    output logic [obj_pkg::obj_rom_aw-1:0]  rom_addr,
    input  logic [31:0]                     rom_data,
    output logic                            rom_cs,
    input  logic                            rom_ok,
    output logic [obj_pkg::obj_pxl_w-1:0]   pxl
);
    import obj_pkg::*;

    logic [2*obj_pxl_w-1:0] pal_addr;
    logic [obj_buf_aw-1:0]  wr_addr;
    logic                   wr_en;
    logic [obj_pxl_w-1:0]   buf_data;
    logic [obj_buf_aw-1:0]  buf_addr;
    logic                   buf_we;

    obj_req_if req_i ();

    // host side of the request
    assign req_i.draw  = draw;
    assign req_i.code  = code;
    assign req_i.row   = row;
    assign req_i.xpos  = xpos;
    assign req_i.pal   = pal;
    assign req_i.hflip = hflip;
    assign req_i.vflip = vflip;
    assign busy        = req_i.busy;

    obj_fetch fetch_i (
        .rst      (rst),
        .clk      (clk),
        .cen      (cen),
        .req      (req_i.drawer),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .pal_addr (pal_addr),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en)
    );

    obj_palette palette_i (
        .clk       (clk),
        .rst       (rst),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .pal_addr  (pal_addr),
        .wr_addr   (wr_addr),
        .wr_en     (wr_en),
        .buf_data  (buf_data),
        .buf_addr  (buf_addr),
        .buf_we    (buf_we)
    );

    obj_line_buffer buffer_i (
        .rst      (rst),
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .hinit    (hinit),
        .hdump    (hdump),
        .buf_data (buf_data),
        .buf_addr (buf_addr),
        .buf_we   (buf_we),
        .pxl      (pxl)
    );

endmodule

/* tb/tb_clock.sv */
// testbench clock and reset source, instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clock #(
    parameter real period_ns  = 100.0,
    parameter int  rst_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released on the drive edge
    end

endmodule

/* tb/obj_draw_tb.sv */
// top of the sprite renderer testbench with ROM model and line checks, compiled last from files.f
`timescale 1ns/1ps

module obj_draw_tb;
    import obj_pkg::*;

    localparam int busy_limit = 200;  // longest sprite needs about 30 cycles

    logic        clk, rst, cen, pxl_cen, lhbl, hinit, draw, hflip, vflip, busy;
    logic [7:0]  hdump, xpos, prog_addr;
    logic [8:0]  code;
    logic [3:0]  row, pal, prog_data, pxl;
    logic        prog_en, rom_cs, rom_ok;
    logic [13:0] rom_addr;
    logic [31:0] rom_data;

    int          errors;
    int          timeouts;
    string       test_name;
    logic [31:0] stim_rnd;
    logic [31:0] rom_rnd;       // separate stream for the ROM delays
    int          rom_dly;
    logic [13:0] rom_q;         // address at request start
    logic [13:0] rom_log [$];
    logic [3:0]  exp_line [256];

    tb_clock #(.period_ns(100.0), .rst_cycles(4)) clock_i (.clk(clk), .rst(rst));

    obj_draw dut_i (
        .rst(rst), .clk(clk), .cen(cen), .pxl_cen(pxl_cen), .lhbl(lhbl), .hinit(hinit),
        .hdump(hdump), .draw(draw), .code(code), .row(row), .xpos(xpos), .pal(pal),
        .hflip(hflip), .vflip(vflip), .busy(busy), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_en(prog_en), .rom_addr(rom_addr), .rom_data(rom_data),
        .rom_cs(rom_cs), .rom_ok(rom_ok), .pxl(pxl)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // graphics word stored at a ROM address
    function automatic logic [31:0] rom_hash(input logic [13:0] a);
        return xorshift(xorshift({18'd0, a} ^ 32'h5bd1_e995));
    endfunction

    // one plane bit per nibble with pixels 4 to 7 in the upper half
    function automatic logic [3:0] pixel_of(input logic [31:0] w, input int n);
        int col;
        int hi;
        col = n & 3;
        hi  = (n >> 2) * 16;
        pixel_of[3] = w[hi + 8 + col];
        pixel_of[2] = w[hi + 12 + col];
        pixel_of[1] = w[hi + col];
        pixel_of[0] = w[hi + 4 + col];
    endfunction

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERROR [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    // paint one sprite into the expected line over earlier ones
    function automatic void paint_expected(input logic [8:0] c, input logic [3:0] r,
                                           input logic [7:0] x, input logic [3:0] p,
                                           input logic hf, input logic vf);
        logic [31:0] w;
        logic [3:0]  col;
        logic [7:0]  pos;
        int          i;
        for (int h = 0; h < 2; h++) begin
            w = rom_hash({c, r ^ {4{vf}}, h[0]});
            for (int n = 0; n < 8; n++) begin
                i   = h * 8 + n;
                pos = x + obj_hoffset + (hf ? 8'(15 - i) : 8'(i));
                col = p ^ pixel_of(w, n);  // palette entry is low nibble xor high nibble
                if (col != 4'd0)
                    exp_line[pos] = col;
            end
        end
    endfunction

    // ROM with a random answer delay that also checks the address holds during the stall
    always @(negedge clk) begin
        if (rom_cs !== 1'b1) begin
            rom_ok  = 1'b0;
            rom_dly = -1;
        end else if (!rom_ok) begin
            if (rom_dly < 0) begin
                rom_rnd = xorshift(rom_rnd);
                rom_dly = rom_rnd % 6;
                rom_q   = rom_addr;
                rom_log.push_back(rom_addr);
            end else begin
                check_eq("rom address during stall", rom_q, rom_addr);
            end
            if (rom_dly == 0) begin
                rom_data = rom_hash(rom_addr);
                rom_ok   = 1'b1;
            end else begin
                rom_data = rom_rnd;  // junk while not ready
                rom_dly--;
            end
        end
    end

    task automatic draw_sprite(input logic [8:0] c, input logic [3:0] r, input logic [7:0] x,
                               input logic [3:0] p, input logic hf, input logic vf,
                               input bit redraw);
        int          t;
        logic [13:0] a0;
        a0 = {c, r ^ {4{vf}}, 1'b0};
        rom_log.delete();
        code  = c;
        row   = r;
        xpos  = x;
        pal   = p;
        hflip = hf;
        vflip = vf;
        draw  = 1'b1;
        @(negedge clk);
        draw = 1'b0;
        check_eq("busy after draw", 1, busy);
        paint_expected(c, r, x, p, hf, vf);
        t = 0;
        while (busy && t < busy_limit) begin
            draw = redraw && (t == 3);  // pulse while busy that must be ignored
            @(negedge clk);
            t++;
        end
        draw = 1'b0;
        if (busy) begin
            timeouts++;
            $display("timeout: busy stayed high for sprite code %0h", c);
        end
        check_eq("rom requests per sprite", 2, rom_log.size());
        if (rom_log.size() > 0)
            check_eq("rom address half 0", a0, rom_log[0]);
        if (rom_log.size() > 1)
            check_eq("rom address half 1", a0 | 14'd1, rom_log[1]);
        repeat (2) @(negedge clk);  // let the last pixel reach the buffer
    endtask

    // swap banks and read a whole line before clearing the expected contents
    task automatic read_line(input string name);
        test_name = name;
        hinit = 1'b1;
        @(negedge clk);
        hinit = 1'b0;
        lhbl  = 1'b1;
        hdump = 8'd0;
        repeat (int'(obj_hoffset) - 1) @(negedge clk);  // blanking delay
        for (int h = 0; h < 256; h++) begin
            hdump = 8'(h);
            @(negedge clk);
            check_eq($sformatf("pxl at %0d", h), exp_line[h], pxl);
        end
        lhbl = 1'b0;
        repeat (int'(obj_hoffset) + 1) @(negedge clk);
        for (int i = 0; i < 256; i++)
            exp_line[i] = 4'd0;
    endtask

    initial begin
        logic [31:0] r;
        logic        hf, vf;
        int          t;
        errors = 0;
        timeouts = 0;
        stim_rnd = 32'h2aa4;
        rom_rnd = 32'h2aa4;
        rom_dly = -1;
        {cen, pxl_cen} = 2'b11;
        {lhbl, hinit, draw, hflip, vflip, prog_en, rom_ok} = '0;
        {hdump, code, row, xpos, pal, prog_addr, prog_data} = '0;
        rom_data = '0;
        for (int i = 0; i < 256; i++)
            exp_line[i] = 4'd0;

        test_name = "reset idle";
        t = 0;
        while (rst && t < 50) begin
            @(posedge clk);
            t++;
        end
        if (rst) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
        @(negedge clk);
        for (int a = 0; a < 256; a++) begin
            prog_addr = 8'(a);
            prog_data = prog_addr[3:0] ^ prog_addr[7:4];
            prog_en   = 1'b1;
            @(negedge clk);
            check_eq("outputs before first draw", 0, {busy, rom_cs, pxl});
        end
        prog_en = 1'b0;

        // overlapping sprites with fixed flips on the first three and a redraw pulse on the fourth
        test_name = "line a";
        for (int s = 0; s < 6; s++) begin
            stim_rnd = xorshift(stim_rnd);
            r  = stim_rnd;
            hf = (s == 1) ? 1'b1 : (s < 3) ? 1'b0 : r[22];
            vf = (s == 2) ? 1'b1 : (s < 2) ? 1'b0 : r[23];
            draw_sprite(r[8:0], r[12:9], 8'd40 + {3'd0, r[17:13]}, r[21:18], hf, vf, s == 3);
        end
        read_line("line a");

        test_name = "line b";
        for (int s = 0; s < 4; s++) begin
            stim_rnd = xorshift(stim_rnd);
            r = stim_rnd;
            draw_sprite(r[8:0], r[12:9], r[20:13], r[24:21], r[25], r[26], s == 0);
        end
        read_line("line b");

        // both banks were read once so both must come back blank
        read_line("erase bank 1");
        read_line("erase bank 0");

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* files.f */
design/obj_pkg.sv
design/obj_req_if.sv
design/obj_fetch.sv
design/obj_palette.sv
design/obj_line_buffer.sv
design/obj_draw.sv
tb/tb_clock.sv
tb/obj_draw_tb.sv
